// File: list.f
+incdir+verif
common/tl_pkg.sv
hw/dcache_tag/dcache_tag_array.sv
hw/store_buffer/store_buffer.sv
hw/tl_hazard_ctrl.sv
hw/tl_stage_latch.sv
hw/tl_stage.sv
verif/tl_stage_tb.sv

// File: Makefile
# Verilator build and run of the tag-lookup stage testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f list.f --top-module tl_stage_tb \
		-Mdir obj_dir -o tl_stage_tb

# The log decides the result, a missing pass line fails the target
run: compile
	./obj_dir/tl_stage_tb | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: verif/tl_stage_model.svh
`ifndef TL_STAGE_MODEL_SVH
`define TL_STAGE_MODEL_SVH

// Model state, updated once per clock edge
logic [TAG_W-1:0]  m_tag [NUM_LINES];
logic              m_tag_v [NUM_LINES];
addr_t             m_sb_addr [$];
word_t             m_sb_data [$];
tl_state_e         m_state;
logic [TAG_W-1:0]  m_inflight;

// Expected results for the cycle just evaluated
logic              e_hazard;
logic              e_mmu_miss;
logic              e_flush;
addr_t             e_flush_addr;
word_t             e_flush_data;
logic              e_hit;
word_t             e_load_data;
logic              e_rd;
logic              e_we;
logic              e_pass;
addr_t             e_addr;
reg_addr_t         e_waddr;
logic [IDX_W-1:0]  e_index;

task automatic model_reset();
    for (int i = 0; i < NUM_LINES; i++) begin
        m_tag_v[i] = 1'b0;
    end
    m_sb_addr.delete();
    m_sb_data.delete();
    m_state    = TL_IDLE;
    m_inflight = '0;
endtask

task automatic model_step(input logic rd, input logic wr, input addr_t a, input word_t d,
                          input logic perm, input logic we, input reg_addr_t wa,
                          input logic rdy, input addr_t fa, input logic [IDX_W-1:0] fidx);
    logic      req_ok;
    logic      ld;
    logic      st;
    logic      t_match;
    logic      t_miss;
    logic      s_match;
    logic      full;
    logic      trouble;
    logic      flush;
    logic      ld_miss;
    logic      conflict;
    logic      haz;
    int        t_idx;
    int        s_idx;
    tl_state_e nxt;

    req_ok  = (m_state == TL_IDLE) || (m_state == MISS_IN_FLIGHT);
    ld      = req_ok && rd;
    st      = req_ok && wr;
    t_match = 1'b0;
    t_idx   = 0;
    for (int i = 0; i < NUM_LINES; i++) begin
        if (m_tag_v[i] && m_tag[i] == a[ADDR_W-1:LINE_OFFSET_W]) begin
            t_match = 1'b1;
            t_idx   = i;
        end
    end
    s_match = 1'b0;
    s_idx   = 0;
    foreach (m_sb_addr[i]) begin
        if (m_sb_addr[i][ADDR_W-1:2] == a[ADDR_W-1:2]) begin
            s_match = 1'b1;
            s_idx   = i;
        end
    end
    t_miss   = (ld || st) && !t_match;
    full     = m_sb_addr.size() == SB_ENTRIES;
    trouble  = st && !s_match && full;
    flush    = (m_sb_addr.size() != 0) && perm &&
               ((m_state == TL_IDLE && !rd && !wr) || m_state == HAZARD_SB_TROUBLE);
    ld_miss  = ld && t_miss && !s_match;
    conflict = (t_miss && m_inflight != a[ADDR_W-1:LINE_OFFSET_W]) || ld_miss;

    nxt = m_state;
    haz = 1'b1;
    case (m_state)
        TL_IDLE: begin
            haz = ld_miss || trouble;
            if (st && t_miss) begin
                nxt        = trouble ? HAZARD_SB_TROUBLE : MISS_IN_FLIGHT;
                m_inflight = a[ADDR_W-1:LINE_OFFSET_W];
            end else if (ld_miss) begin
                nxt = HAZARD_DC_MISS;
            end else if (trouble) begin
                nxt = HAZARD_SB_TROUBLE;
            end
        end
        MISS_IN_FLIGHT: begin
            haz = conflict || trouble;
            if (conflict) nxt = HAZARD_DC_MISS;
            else if (trouble) nxt = HAZARD_SB_TROUBLE;
            else if (rdy) nxt = TL_IDLE;
        end
        HAZARD_DC_MISS: begin
            if (rdy) nxt = TL_IDLE;
        end
        default: begin
            if (!trouble) nxt = TL_IDLE;
        end
    endcase

    e_hazard   = haz;
    e_mmu_miss = (ld || st) && t_miss && !s_match;
    e_flush    = flush && (!haz || m_state == HAZARD_SB_TROUBLE);
    if (flush) begin
        e_flush_addr = m_sb_addr[0];
        e_flush_data = m_sb_data[0];
    end
    e_hit = !haz && !flush && ld && s_match;
    if (s_match) e_load_data = m_sb_data[s_idx];
    e_rd    = rd && !haz;
    e_we    = we && !haz;
    e_pass  = !haz;
    e_addr  = a;
    e_waddr = wa;
    e_index = IDX_W'(t_idx);

    // Merge before the drain, the drain still shows the old word
    if (st && s_match) m_sb_data[s_idx] = d;
    if (flush) begin
        void'(m_sb_addr.pop_front());
        void'(m_sb_data.pop_front());
    end
    if (st && !s_match && !full) begin
        m_sb_addr.push_back({a[ADDR_W-1:2], 2'b00});
        m_sb_data.push_back(d);
    end
    if (rdy) begin
        m_tag[fidx]   = fa[ADDR_W-1:LINE_OFFSET_W];
        m_tag_v[fidx] = 1'b1;
    end
    m_state = nxt;
endtask

`endif

// File: verif/tl_stage_tb.sv
module tl_stage_tb
    import tl_pkg::*;
;

    localparam int NUM_LINES   = 8;
    localparam int SB_ENTRIES  = 4;
    localparam int IDX_W       = $clog2(NUM_LINES);
    localparam int NUM_CYCLES  = 4000;
    localparam int STALL_LIMIT = 200;

    logic             clk_i;
    logic             arst_n_i;
    addr_t            addr_i;
    logic             rf_we_i;
    reg_addr_t        rf_waddr_i;
    word_t            rf_st_data_i;
    logic             memop_rd_i;
    logic             memop_wr_i;
    logic             store_permission_i;
    logic             mmu_data_rdy_i;
    addr_t            mmu_addr_i;
    logic [IDX_W-1:0] mmu_lru_index_i;
    addr_t            addr_o;
    logic             rf_we_o;
    reg_addr_t        rf_waddr_o;
    logic [IDX_W-1:0] addr_index_o;
    logic             memop_rd_o;
    logic             memop_wr_o;
    logic             sb_hit_o;
    logic             sb_flush_o;
    word_t            sb_data_load_o;
    word_t            sb_data_flush_o;
    addr_t            sb_addr_o;
    logic             mmu_miss_o;
    addr_t            mmu_addr_o;
    logic             pipeline_hazard_o;

    int               errors;
    int               checks;
    logic             mmu_busy;
    int               mmu_wait;
    addr_t            mmu_line;

    `include "tl_stage_model.svh"

    tl_stage #(
        .NUM_LINES  (NUM_LINES),
        .SB_ENTRIES (SB_ENTRIES)
    ) tl_stage_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    task automatic report_error(input string msg);
        $display("ERROR at time %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic expect_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) report_error($sformatf("%s is %b, expected %b", name, got, exp));
    endtask

    task automatic expect_word(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) report_error($sformatf("%s is %h, expected %h", name, got, exp));
    endtask

    // 12 words over 6 lines with two words per line
    function automatic addr_t pool_addr(input int slot);
        return 32'h8000_0000 + 32'((slot / 2) * 16 + (slot % 2) * 4);
    endfunction

    // MMU fill pulse when the current miss has waited long enough
    task automatic drive_mmu();
        mmu_data_rdy_i = 1'b0;
        if (mmu_busy) begin
            if (mmu_wait == 0) begin
                mmu_data_rdy_i  = 1'b1;
                mmu_addr_i      = mmu_line;
                mmu_lru_index_i = IDX_W'($urandom % NUM_LINES);
                mmu_busy        = 1'b0;
            end else begin
                mmu_wait--;
            end
        end
    endtask

    task automatic pick_request();
        int op;
        op           = int'($urandom % 8);
        addr_i       = pool_addr(int'($urandom % 12));
        memop_rd_i   = (op >= 3 && op <= 5);
        memop_wr_i   = (op >= 6);
        rf_we_i      = 1'($urandom % 2);
        rf_waddr_i   = 5'($urandom % 32);
        rf_st_data_i = $urandom;
    endtask

    task automatic check_comb();
        expect_bit("pipeline_hazard_o", pipeline_hazard_o, e_hazard);
        expect_bit("mmu_miss_o", mmu_miss_o, e_mmu_miss);
        if (mmu_data_rdy_i) begin
            expect_word("mmu_addr_o during a fill", mmu_addr_o, {mmu_addr_i[31:4], 4'h0});
        end else if (e_mmu_miss) begin
            expect_word("mmu_addr_o", mmu_addr_o, {addr_i[31:4], 4'h0});
        end
    endtask

    task automatic check_registered();
        expect_bit("rf_we_o", rf_we_o, e_we);
        expect_bit("memop_rd_o", memop_rd_o, e_rd);
        expect_bit("memop_wr_o", memop_wr_o, e_flush);
        expect_bit("sb_flush_o", sb_flush_o, e_flush);
        expect_bit("sb_hit_o", sb_hit_o, e_hit);
        if (e_flush) begin
            expect_word("sb_addr_o", sb_addr_o, e_flush_addr);
            expect_word("sb_data_flush_o", sb_data_flush_o, e_flush_data);
        end
        if (e_hit) expect_word("sb_data_load_o", sb_data_load_o, e_load_data);
        if (e_pass) begin
            expect_word("addr_o", addr_o, e_addr);
            expect_word("rf_waddr_o", 32'(rf_waddr_o), 32'(e_waddr));
            expect_word("addr_index_o", 32'(addr_index_o), 32'(e_index));
        end
    endtask

    initial begin
        logic stalled;
        int   stall_cnt;
        logic timed_out;

        void'($urandom(32'h3ac0a387));
        errors             = 0;
        checks             = 0;
        stalled            = 1'b0;
        stall_cnt          = 0;
        timed_out          = 1'b0;
        mmu_busy           = 1'b0;
        mmu_wait           = 0;
        mmu_line           = '0;
        arst_n_i           = 1'b0;
        addr_i             = '0;
        rf_we_i            = 1'b0;
        rf_waddr_i         = '0;
        rf_st_data_i       = '0;
        memop_rd_i         = 1'b0;
        memop_wr_i         = 1'b0;
        store_permission_i = 1'b0;
        mmu_data_rdy_i     = 1'b0;
        mmu_addr_i         = '0;
        mmu_lru_index_i    = '0;
        model_reset();

        repeat (10) @(posedge clk_i);
        #5 arst_n_i = 1'b1;
        expect_bit("rf_we_o after reset", rf_we_o, 1'b0);
        expect_bit("memop_rd_o after reset", memop_rd_o, 1'b0);
        expect_bit("memop_wr_o after reset", memop_wr_o, 1'b0);
        expect_bit("sb_hit_o after reset", sb_hit_o, 1'b0);
        expect_bit("sb_flush_o after reset", sb_flush_o, 1'b0);
        expect_bit("pipeline_hazard_o after reset", pipeline_hazard_o, 1'b0);
        expect_bit("mmu_miss_o after reset", mmu_miss_o, 1'b0);

        for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            drive_mmu();
            // Execute holds its request during a stall
            if (!stalled) pick_request();
            store_permission_i = 1'($urandom % 2);

            @(negedge clk_i);
            model_step(memop_rd_i, memop_wr_i, addr_i, rf_st_data_i, store_permission_i,
                       rf_we_i, rf_waddr_i, mmu_data_rdy_i, mmu_addr_i, mmu_lru_index_i);
            check_comb();
            // The MMU also answers a stall so that every stall ends
            if (!mmu_busy && !mmu_data_rdy_i && (mmu_miss_o || pipeline_hazard_o)) begin
                mmu_busy = 1'b1;
                mmu_wait = 1 + int'($urandom % 5);
                mmu_line = mmu_addr_o;
            end
            stalled   = pipeline_hazard_o;
            stall_cnt = stalled ? stall_cnt + 1 : 0;
            if (stall_cnt > STALL_LIMIT) begin
                $display("Timeout: the stage stalled for more than %0d cycles", STALL_LIMIT);
                timed_out = 1'b1;
                break;
            end

            @(posedge clk_i);
            #1 check_registered();
            #4;
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule : tl_stage_tb

// File: hw/tl_stage.sv
module tl_stage
    import tl_pkg::*;
#(
    parameter int  NUM_LINES  = 8,
    parameter int  SB_ENTRIES = 4,
    localparam int IDX_W      = $clog2(NUM_LINES)
) (
    input  logic             clk_i,
    input  logic             arst_n_i,
    // Execute side
    input  addr_t            addr_i,
    input  logic             rf_we_i,
    input  reg_addr_t        rf_waddr_i,
    input  word_t            rf_st_data_i,
    input  logic             memop_rd_i,
    input  logic             memop_wr_i,
    input  logic             store_permission_i,
    // Memory stage side
    output addr_t            addr_o,
    output logic             rf_we_o,
    output reg_addr_t        rf_waddr_o,
    output logic [IDX_W-1:0] addr_index_o,
    output logic             memop_rd_o,
    output logic             memop_wr_o,
    output logic             sb_hit_o,
    output logic             sb_flush_o,
    output word_t            sb_data_load_o,
    output word_t            sb_data_flush_o,
    output addr_t            sb_addr_o,
    // MMU
    input  logic             mmu_data_rdy_i,
    input  addr_t            mmu_addr_i,
    input  logic [IDX_W-1:0] mmu_lru_index_i,
    output logic             mmu_miss_o,
    output addr_t            mmu_addr_o,
    output logic             pipeline_hazard_o
);

    logic             tag_req;
    logic             tag_hit;
    logic             tag_miss;
    logic [IDX_W-1:0] tag_index;
    logic             sb_req_store;
    logic             sb_req_load;
    logic             sb_flush_chance;
    logic             sb_hit;
    logic             sb_miss;
    logic             sb_trouble;
    logic             sb_data_valid;
    word_t            sb_data_load;
    word_t            sb_data_flush;
    addr_t            sb_addr_flush;
    tl_state_e        state;

    dcache_tag_array #(
        .NUM_LINES (NUM_LINES)
    ) u_tag_array (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .req_i        (tag_req),
        .addr_i       (addr_i),
        .fill_i       (mmu_data_rdy_i),
        .fill_addr_i  (mmu_addr_i),
        .fill_index_i (mmu_lru_index_i),
        .hit_o        (tag_hit),
        .miss_o       (tag_miss),
        .hit_index_o  (tag_index),
        .miss_addr_o  (mmu_addr_o)
    );

    store_buffer #(
        .SB_ENTRIES (SB_ENTRIES)
    ) u_store_buffer (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .req_store_i    (sb_req_store),
        .req_load_i     (sb_req_load),
        .flush_chance_i (sb_flush_chance),
        .addr_i         (addr_i),
        .data_i         (rf_st_data_i),
        .hit_o          (sb_hit),
        .miss_o         (sb_miss),
        .trouble_o      (sb_trouble),
        .data_valid_o   (sb_data_valid),
        .data_load_o    (sb_data_load),
        .data_flush_o   (sb_data_flush),
        .addr_flush_o   (sb_addr_flush)
    );

    tl_hazard_ctrl u_hazard_ctrl (
        .clk_i              (clk_i),
        .arst_n_i           (arst_n_i),
        .memop_rd_i         (memop_rd_i),
        .memop_wr_i         (memop_wr_i),
        .addr_i             (addr_i),
        .store_permission_i (store_permission_i),
        .mmu_data_rdy_i     (mmu_data_rdy_i),
        .tag_hit_i          (tag_hit),
        .tag_miss_i         (tag_miss),
        .sb_hit_i           (sb_hit),
        .sb_miss_i          (sb_miss),
        .sb_trouble_i       (sb_trouble),
        .sb_data_valid_i    (sb_data_valid),
        .tag_req_o          (tag_req),
        .sb_req_store_o     (sb_req_store),
        .sb_req_load_o      (sb_req_load),
        .flush_chance_o     (sb_flush_chance),
        .mmu_miss_o         (mmu_miss_o),
        .state_o            (state),
        .hazard_o           (pipeline_hazard_o)
    );

    tl_stage_latch #(
        .NUM_LINES (NUM_LINES)
    ) u_stage_latch (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .hazard_i        (pipeline_hazard_o),
        .state_i         (state),
        .flush_chance_i  (sb_flush_chance),
        .sb_data_valid_i (sb_data_valid),
        .sb_hit_i        (sb_hit),
        .memop_rd_i      (memop_rd_i),
        .rf_we_i         (rf_we_i),
        .rf_waddr_i      (rf_waddr_i),
        .addr_i          (addr_i),
        .tag_index_i     (tag_index),
        .sb_data_load_i  (sb_data_load),
        .sb_data_flush_i (sb_data_flush),
        .sb_addr_flush_i (sb_addr_flush),
        .addr_o          (addr_o),
        .rf_we_o         (rf_we_o),
        .rf_waddr_o      (rf_waddr_o),
        .addr_index_o    (addr_index_o),
        .memop_rd_o      (memop_rd_o),
        .memop_wr_o      (memop_wr_o),
        .sb_hit_o        (sb_hit_o),
        .sb_flush_o      (sb_flush_o),
        .sb_data_load_o  (sb_data_load_o),
        .sb_data_flush_o (sb_data_flush_o),
        .sb_addr_o       (sb_addr_o)
    );

endmodule : tl_stage

// File: hw/tl_stage_latch.sv
module tl_stage_latch
    import tl_pkg::*;
#(
    parameter int  NUM_LINES = 8,
    localparam int IDX_W     = $clog2(NUM_LINES)
) (
    input  logic             clk_i,
    input  logic             arst_n_i,
    input  logic             hazard_i,
    input  tl_state_e        state_i,
    input  logic             flush_chance_i,
    input  logic             sb_data_valid_i,
    input  logic             sb_hit_i,
    input  logic             memop_rd_i,
    input  logic             rf_we_i,
    input  reg_addr_t        rf_waddr_i,
    input  addr_t            addr_i,
    input  logic [IDX_W-1:0] tag_index_i,
    input  word_t            sb_data_load_i,
    input  word_t            sb_data_flush_i,
    input  addr_t            sb_addr_flush_i,
    output addr_t            addr_o,
    output logic             rf_we_o,
    output reg_addr_t        rf_waddr_o,
    output logic [IDX_W-1:0] addr_index_o,
    output logic             memop_rd_o,
    output logic             memop_wr_o,
    output logic             sb_hit_o,
    output logic             sb_flush_o,
    output word_t            sb_data_load_o,
    output word_t            sb_data_flush_o,
    output addr_t            sb_addr_o
);

    logic drain;
    logic fwd_load;
    logic show_drain;

    assign drain    = flush_chance_i && sb_data_valid_i;
    assign fwd_load = memop_rd_i && sb_hit_i;

    // A stall still lets the buffer drain while it is full
    assign show_drain = drain && (!hazard_i || state_i == HAZARD_SB_TROUBLE);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rf_we_o    <= 1'b0;
            memop_rd_o <= 1'b0;
            memop_wr_o <= 1'b0;
            sb_hit_o   <= 1'b0;
            sb_flush_o <= 1'b0;
        end else begin
            rf_we_o    <= rf_we_i && !hazard_i;
            memop_rd_o <= memop_rd_i && !hazard_i;
            memop_wr_o <= show_drain;
            sb_flush_o <= show_drain;
            sb_hit_o   <= !hazard_i && !drain && fwd_load;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!hazard_i) begin
            addr_o       <= addr_i;
            rf_waddr_o   <= rf_waddr_i;
            addr_index_o <= tag_index_i;
        end
        if (show_drain) begin
            sb_addr_o       <= sb_addr_flush_i;
            sb_data_flush_o <= sb_data_flush_i;
        end
        if (!hazard_i && fwd_load) begin
            sb_data_load_o <= sb_data_load_i;
        end
    end

endmodule : tl_stage_latch

// File: hw/tl_hazard_ctrl.sv
module tl_hazard_ctrl
    import tl_pkg::*;
(
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      memop_rd_i,
    input  logic      memop_wr_i,
    input  addr_t     addr_i,
    input  logic      store_permission_i,
    input  logic      mmu_data_rdy_i,
    input  logic      tag_hit_i,
    input  logic      tag_miss_i,
    input  logic      sb_hit_i,
    input  logic      sb_miss_i,
    input  logic      sb_trouble_i,
    input  logic      sb_data_valid_i,
    output logic      tag_req_o,
    output logic      sb_req_store_o,
    output logic      sb_req_load_o,
    output logic      flush_chance_o,
    output logic      mmu_miss_o,
    output tl_state_e state_o,
    output logic      hazard_o
);

    tl_state_e state_q;
    tl_state_e state_d;
    tag_t      tag_in_flight_q;
    logic      req_ok;
    logic      diff_tag;
    logic      mif_conflict;
    logic      idle_ld_miss;

    // Requests only pass while not parked in a hazard state
    assign req_ok         = (state_q == TL_IDLE) || (state_q == MISS_IN_FLIGHT);
    assign tag_req_o      = req_ok && (memop_rd_i || memop_wr_i);
    assign sb_req_store_o = req_ok && memop_wr_i;
    assign sb_req_load_o  = req_ok && memop_rd_i;

    assign flush_chance_o = sb_data_valid_i && store_permission_i &&
        ((state_q == TL_IDLE && !memop_rd_i && !memop_wr_i) ||
         (state_q == HAZARD_SB_TROUBLE));

    assign mmu_miss_o = (sb_req_load_o || sb_req_store_o) && tag_miss_i && sb_miss_i;

    assign diff_tag     = tag_in_flight_q != addr_i[ADDR_W-1:LINE_OFFSET_W];
    assign idle_ld_miss = sb_req_load_o && tag_miss_i && !sb_hit_i;

    // Second miss while the first store miss is still out
    assign mif_conflict = (tag_miss_i && diff_tag) ||
                          (sb_req_load_o && tag_miss_i && sb_miss_i);

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            TL_IDLE: begin
                if (sb_req_store_o && tag_miss_i) begin
                    state_d = sb_trouble_i ? HAZARD_SB_TROUBLE : MISS_IN_FLIGHT;
                end else if (idle_ld_miss) begin
                    state_d = HAZARD_DC_MISS;
                end else if (sb_trouble_i) begin
                    state_d = HAZARD_SB_TROUBLE;
                end
            end
            MISS_IN_FLIGHT: begin
                if (mif_conflict) begin
                    state_d = HAZARD_DC_MISS;
                end else if (sb_trouble_i) begin
                    // Full buffer, the store would be lost
                    state_d = HAZARD_SB_TROUBLE;
                end else if (mmu_data_rdy_i) begin
                    state_d = TL_IDLE;
                end
            end
            HAZARD_DC_MISS: begin
                if (mmu_data_rdy_i) state_d = TL_IDLE;
            end
            HAZARD_SB_TROUBLE: begin
                if (!sb_trouble_i) state_d = TL_IDLE;
            end
            default: state_d = TL_IDLE;
        endcase
    end

    always_comb begin
        unique case (state_q)
            TL_IDLE:        hazard_o = idle_ld_miss || (sb_req_store_o && sb_trouble_i);
            MISS_IN_FLIGHT: hazard_o = mif_conflict || sb_trouble_i;
            default:        hazard_o = 1'b1;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= TL_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Tag of the store miss the MMU is serving
    always_ff @(posedge clk_i) begin
        if (state_q == TL_IDLE && sb_req_store_o && tag_miss_i) begin
            tag_in_flight_q <= addr_i[ADDR_W-1:LINE_OFFSET_W];
        end
    end

    assign state_o = state_q;

    a_hazard_states_stall : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (state_q inside {HAZARD_DC_MISS, HAZARD_SB_TROUBLE}) |-> hazard_o
    );

    // Tag array answers every lookup with exactly one of hit or miss
    a_tag_answer : assert property (
        @(posedge clk_i) disable iff (!arst_n_i) tag_req_o |-> (tag_hit_i != tag_miss_i)
    );

endmodule : tl_hazard_ctrl

// File: hw/store_buffer/store_buffer.sv
module store_buffer
    import tl_pkg::*;
#(
    parameter int  SB_ENTRIES = 4,
    localparam int PTR_W      = $clog2(SB_ENTRIES)
) (
    input  logic  clk_i,
    input  logic  arst_n_i,
    input  logic  req_store_i,
    input  logic  req_load_i,
    input  logic  flush_chance_i,
    input  addr_t addr_i,
    input  word_t data_i,
    output logic  hit_o,
    output logic  miss_o,
    output logic  trouble_o,
    output logic  data_valid_o,
    output word_t data_load_o,
    output word_t data_flush_o,
    output addr_t addr_flush_o
);

    // Byte offset inside a word
    localparam int BYTE_W = $clog2(WORD_W / 8);

    addr_t                 addr_q [SB_ENTRIES];
    word_t                 data_q [SB_ENTRIES];
    logic [SB_ENTRIES-1:0] valid_q;
    logic [PTR_W-1:0]      head_q;
    logic [PTR_W-1:0]      tail_q;
    logic [PTR_W-1:0]      match_idx;
    logic                  match_any;
    logic                  full;
    logic                  empty;
    logic                  alloc;
    logic                  merge;
    logic                  drain;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(SB_ENTRIES - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Word-address match, merges keep every word unique
    always_comb begin
        match_any = 1'b0;
        match_idx = '0;
        for (int i = 0; i < SB_ENTRIES; i++) begin
            if (valid_q[i] && addr_q[i][ADDR_W-1:BYTE_W] == addr_i[ADDR_W-1:BYTE_W]) begin
                match_any = 1'b1;
                match_idx = PTR_W'(i);
            end
        end
    end

    assign full  = &valid_q;
    assign empty = ~|valid_q;
    assign merge = req_store_i && match_any;
    assign alloc = req_store_i && !match_any && !full;
    assign drain = flush_chance_i && !empty;

    assign hit_o        = (req_store_i || req_load_i) && match_any;
    assign miss_o       = (req_store_i || req_load_i) && !match_any;
    assign trouble_o    = req_store_i && !match_any && full;
    assign data_valid_o = !empty;
    assign data_load_o  = data_q[match_idx];

    // Oldest entry is the next to drain
    assign data_flush_o = data_q[head_q];
    assign addr_flush_o = addr_q[head_q];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
            head_q  <= '0;
            tail_q  <= '0;
        end else begin
            if (drain) begin
                valid_q[head_q] <= 1'b0;
                head_q          <= next_ptr(head_q);
            end
            if (alloc) begin
                valid_q[tail_q] <= 1'b1;
                tail_q          <= next_ptr(tail_q);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (alloc) begin
            addr_q[tail_q] <= {addr_i[ADDR_W-1:BYTE_W], {BYTE_W{1'b0}}};
            data_q[tail_q] <= data_i;
        end else if (merge) begin
            data_q[match_idx] <= data_i;
        end
    end

    a_no_alloc_full : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (req_store_i && !match_any && full) |=> (tail_q == $past(tail_q))
    );

    a_no_drain_empty : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (flush_chance_i && empty) |=> (head_q == $past(head_q))
    );

endmodule : store_buffer

// File: hw/dcache_tag/dcache_tag_array.sv
module dcache_tag_array
    import tl_pkg::*;
#(
    parameter int  NUM_LINES = 8,
    localparam int IDX_W     = $clog2(NUM_LINES)
) (
    input  logic             clk_i,
    input  logic             arst_n_i,
    input  logic             req_i,
    input  addr_t            addr_i,
    input  logic             fill_i,
    input  addr_t            fill_addr_i,
    input  logic [IDX_W-1:0] fill_index_i,
    output logic             hit_o,
    output logic             miss_o,
    output logic [IDX_W-1:0] hit_index_o,
    output addr_t            miss_addr_o
);

    tag_t                 tags_q [NUM_LINES];
    logic [NUM_LINES-1:0] valid_q;
    logic [NUM_LINES-1:0] match;

    // Compare against every valid entry at once
    always_comb begin
        for (int i = 0; i < NUM_LINES; i++) begin
            match[i] = valid_q[i] && (tags_q[i] == addr_i[ADDR_W-1:LINE_OFFSET_W]);
        end
    end

    always_comb begin
        hit_index_o = '0;
        for (int i = 0; i < NUM_LINES; i++) begin
            if (match[i]) begin
                hit_index_o = IDX_W'(i);
            end
        end
    end

    assign hit_o  = req_i && (|match);
    assign miss_o = req_i && !(|match);

    // Line address toward the MMU, fill address wins during a fill
    assign miss_addr_o = fill_i ?
        {fill_addr_i[ADDR_W-1:LINE_OFFSET_W], {LINE_OFFSET_W{1'b0}}} :
        {addr_i[ADDR_W-1:LINE_OFFSET_W], {LINE_OFFSET_W{1'b0}}};

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else if (fill_i) begin
            valid_q[fill_index_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            tags_q[fill_index_i] <= fill_addr_i[ADDR_W-1:LINE_OFFSET_W];
        end
    end

    a_hit_miss_exclusive : assert property (
        @(posedge clk_i) disable iff (!arst_n_i) !(hit_o && miss_o)
    );

endmodule : dcache_tag_array

// File: common/tl_pkg.sv
package tl_pkg;

    // Datapath widths
    localparam int ADDR_W        = 32;
    localparam int WORD_W        = 32;
    localparam int REG_ADDR_W    = 5;

    // 16-byte cache lines
    localparam int LINE_OFFSET_W = 4;
    localparam int TAG_W         = ADDR_W - LINE_OFFSET_W;

    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Controller states, shared by the hazard FSM and the stage latch
    typedef enum logic [1:0] {
        TL_IDLE           = 2'd0,
        MISS_IN_FLIGHT    = 2'd1,
        HAZARD_DC_MISS    = 2'd2,
        HAZARD_SB_TROUBLE = 2'd3
    } tl_state_e;

endpackage : tl_pkg
